// File: design/tiny_acc_pkg.sv
// tiny accumulator core: shared word types, instruction fields and operation codes
package tiny_acc_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  bit_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [2:0]  flags_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [2:0]  port_op_t;

    // flag bits
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_S = 2;

    // instruction word fields
    localparam int OPC_LSB   = 12;
    localparam int STACK_LSB = 10;
    localparam int GROUP_LSB = 4;
    localparam int SUB_LSB   = 0;

    // major opcodes
    localparam opcode_t OP_NOARG = 4'd0;
    localparam opcode_t OP_LDW   = 4'd1;
    localparam opcode_t OP_ADD   = 4'd3;
    localparam opcode_t OP_ADC   = 4'd4;
    localparam opcode_t OP_SUB   = 4'd5;
    localparam opcode_t OP_SBB   = 4'd6;
    localparam opcode_t OP_AND   = 4'd8;
    localparam opcode_t OP_OR    = 4'd9;
    localparam opcode_t OP_XOR   = 4'd10;

    // bit group field
    localparam logic [2:0] GRP_NONE = 3'd0;
    localparam logic [2:0] GRP_BWS  = 3'd1;
    localparam logic [2:0] GRP_BWC  = 3'd2;
    localparam logic [2:0] GRP_BWJ  = 3'd3;
    localparam logic [2:0] GRP_BOS  = 3'd4;
    localparam logic [2:0] GRP_BOC  = 3'd5;
    localparam logic [2:0] GRP_BIJ  = 3'd6;
    localparam logic [2:0] GRP_BSL  = 3'd7;

    // sub-opcodes of the no-argument group
    localparam logic [3:0] SUB_NOP = 4'd0;
    localparam logic [3:0] SUB_INC = 4'd1;
    localparam logic [3:0] SUB_DEC = 4'd2;
    localparam logic [3:0] SUB_RTL = 4'd3;
    localparam logic [3:0] SUB_RTR = 4'd4;
    localparam logic [3:0] SUB_NOT = 4'd5;
    localparam logic [3:0] SUB_COM = 4'd6;
    localparam logic [3:0] SUB_MWO = 4'd9;
    localparam logic [3:0] SUB_MIW = 4'd10;
    localparam logic [3:0] SUB_CLW = 4'd11;
    localparam logic [3:0] SUB_CLO = 4'd12;

    // accumulator unit operations
    localparam alu_op_t A_NONE    = 5'd0;
    localparam alu_op_t A_INC     = 5'd1;
    localparam alu_op_t A_DEC     = 5'd2;
    localparam alu_op_t A_RTL     = 5'd3;
    localparam alu_op_t A_RTR     = 5'd4;
    localparam alu_op_t A_NOT     = 5'd5;
    localparam alu_op_t A_COM     = 5'd6;
    localparam alu_op_t A_LOAD    = 5'd7;
    localparam alu_op_t A_ADD     = 5'd8;
    localparam alu_op_t A_ADC     = 5'd9;
    localparam alu_op_t A_SUB     = 5'd10;
    localparam alu_op_t A_SBB     = 5'd11;
    localparam alu_op_t A_AND     = 5'd12;
    localparam alu_op_t A_OR      = 5'd13;
    localparam alu_op_t A_XOR     = 5'd14;
    localparam alu_op_t A_SET     = 5'd15;
    localparam alu_op_t A_CLR     = 5'd16;
    localparam alu_op_t A_BSL     = 5'd17;
    localparam alu_op_t A_CLW     = 5'd18;
    localparam alu_op_t A_IN_LOAD = 5'd19;

    // port unit operations
    localparam port_op_t P_NONE     = 3'd0;
    localparam port_op_t P_SET      = 3'd1;
    localparam port_op_t P_CLEAR    = 3'd2;
    localparam port_op_t P_MWO      = 3'd3;
    localparam port_op_t P_CLR_ALL  = 3'd4;
    localparam port_op_t P_TEST_ACC = 3'd5;
    localparam port_op_t P_TEST_IN  = 3'd6;

endpackage

// File: design/tiny_acc_decode.sv
// instruction decoder: maps one instruction word to an accumulator or port operation
module tiny_acc_decode (
    input  logic                   instr_valid,
    input  tiny_acc_pkg::word_t    instr,
    output tiny_acc_pkg::alu_op_t  alu_op,
    output tiny_acc_pkg::port_op_t port_op,
    output tiny_acc_pkg::bit_idx_t bit_idx
);

    tiny_acc_pkg::opcode_t opcode;
    logic [1:0]            stack_fld;
    logic [2:0]            group;
    logic [3:0]            sub_op;

    assign opcode    = instr[tiny_acc_pkg::OPC_LSB +: 4];
    assign stack_fld = instr[tiny_acc_pkg::STACK_LSB +: 2];
    assign group     = instr[tiny_acc_pkg::GROUP_LSB +: 3];
    assign sub_op    = instr[tiny_acc_pkg::SUB_LSB +: 4];

    // bit index shares the sub-opcode field
    assign bit_idx = instr[tiny_acc_pkg::SUB_LSB +: 4];

    always_comb begin
        alu_op  = tiny_acc_pkg::A_NONE;
        port_op = tiny_acc_pkg::P_NONE;
        // stack forms are gone, so only a clear stack field decodes
        if (instr_valid && stack_fld == 2'b00) begin
            case (opcode)
                tiny_acc_pkg::OP_LDW: alu_op = tiny_acc_pkg::A_LOAD;
                tiny_acc_pkg::OP_ADD: alu_op = tiny_acc_pkg::A_ADD;
                tiny_acc_pkg::OP_ADC: alu_op = tiny_acc_pkg::A_ADC;
                tiny_acc_pkg::OP_SUB: alu_op = tiny_acc_pkg::A_SUB;
                tiny_acc_pkg::OP_SBB: alu_op = tiny_acc_pkg::A_SBB;
                tiny_acc_pkg::OP_AND: alu_op = tiny_acc_pkg::A_AND;
                tiny_acc_pkg::OP_OR:  alu_op = tiny_acc_pkg::A_OR;
                tiny_acc_pkg::OP_XOR: alu_op = tiny_acc_pkg::A_XOR;
                tiny_acc_pkg::OP_NOARG: begin
                    case (group)
                        tiny_acc_pkg::GRP_BWS: alu_op  = tiny_acc_pkg::A_SET;
                        tiny_acc_pkg::GRP_BWC: alu_op  = tiny_acc_pkg::A_CLR;
                        tiny_acc_pkg::GRP_BWJ: port_op = tiny_acc_pkg::P_TEST_ACC;
                        tiny_acc_pkg::GRP_BOS: port_op = tiny_acc_pkg::P_SET;
                        tiny_acc_pkg::GRP_BOC: port_op = tiny_acc_pkg::P_CLEAR;
                        tiny_acc_pkg::GRP_BIJ: port_op = tiny_acc_pkg::P_TEST_IN;
                        tiny_acc_pkg::GRP_BSL: alu_op  = tiny_acc_pkg::A_BSL;
                        tiny_acc_pkg::GRP_NONE: begin
                            case (sub_op)
                                tiny_acc_pkg::SUB_NOP: alu_op = tiny_acc_pkg::A_NONE;
                                tiny_acc_pkg::SUB_INC: alu_op = tiny_acc_pkg::A_INC;
                                tiny_acc_pkg::SUB_DEC: alu_op = tiny_acc_pkg::A_DEC;
                                tiny_acc_pkg::SUB_RTL: alu_op = tiny_acc_pkg::A_RTL;
                                tiny_acc_pkg::SUB_RTR: alu_op = tiny_acc_pkg::A_RTR;
                                tiny_acc_pkg::SUB_NOT: alu_op = tiny_acc_pkg::A_NOT;
                                tiny_acc_pkg::SUB_COM: alu_op = tiny_acc_pkg::A_COM;
                                tiny_acc_pkg::SUB_MIW: alu_op = tiny_acc_pkg::A_IN_LOAD;
                                tiny_acc_pkg::SUB_CLW: alu_op = tiny_acc_pkg::A_CLW;
                                tiny_acc_pkg::SUB_MWO: port_op = tiny_acc_pkg::P_MWO;
                                tiny_acc_pkg::SUB_CLO: port_op = tiny_acc_pkg::P_CLR_ALL;
                                // ldp, stp, psh, rst and spare codes
                                default: alu_op = tiny_acc_pkg::A_NONE;
                            endcase
                        end
                    endcase
                end
                // stw, mod, jumps and calls
                default: alu_op = tiny_acc_pkg::A_NONE;
            endcase
        end
    end

    // the two units never act on the same instruction
    one_unit_per_instr: assert final (
        alu_op == tiny_acc_pkg::A_NONE || port_op == tiny_acc_pkg::P_NONE
    ) else $error("decode: accumulator and port operation active together");

endmodule

// File: design/tiny_acc_alu.sv
// accumulator unit: accumulator register, arithmetic, logic, shifts, bit ops and flags
module tiny_acc_alu (
    input  logic                   clk,
    input  logic                   reset,
    input  tiny_acc_pkg::alu_op_t  alu_op,
    input  tiny_acc_pkg::bit_idx_t bit_idx,
    input  tiny_acc_pkg::word_t    operand,
    input  tiny_acc_pkg::word_t    in,
    output tiny_acc_pkg::word_t    acc,
    output tiny_acc_pkg::flags_t   flags
);

    tiny_acc_pkg::word_t acc_next;
    logic                carry;
    logic                carry_next;
    logic [16:0]         wide;

    assign carry = flags[tiny_acc_pkg::FLAG_C];

    always_comb begin
        acc_next   = acc;
        carry_next = carry;
        wide       = '0;
        case (alu_op)
            tiny_acc_pkg::A_LOAD: begin
                acc_next = operand;
            end
            tiny_acc_pkg::A_ADD: begin
                wide       = {1'b0, acc} + {1'b0, operand};
                acc_next   = wide[15:0];
                carry_next = wide[16];
            end
            tiny_acc_pkg::A_ADC: begin
                wide       = {1'b0, acc} + {1'b0, operand} + {16'b0, carry};
                acc_next   = wide[15:0];
                carry_next = wide[16];
            end
            tiny_acc_pkg::A_SUB: begin
                acc_next   = acc - operand;
                carry_next = acc < operand;
            end
            tiny_acc_pkg::A_SBB: begin
                // borrow compare needs the 17th bit when operand is all ones
                wide       = {1'b0, operand} + {16'b0, carry};
                acc_next   = acc - operand - {15'b0, carry};
                carry_next = {1'b0, acc} < wide;
            end
            tiny_acc_pkg::A_AND: acc_next = acc & operand;
            tiny_acc_pkg::A_OR:  acc_next = acc | operand;
            tiny_acc_pkg::A_XOR: acc_next = acc ^ operand;
            tiny_acc_pkg::A_INC: begin
                wide       = {1'b0, acc} + 17'd1;
                acc_next   = wide[15:0];
                carry_next = wide[16];
            end
            tiny_acc_pkg::A_DEC: begin
                acc_next   = acc - 16'd1;
                carry_next = acc == 16'd0;
            end
            tiny_acc_pkg::A_RTL: begin
                acc_next   = {acc[14:0], 1'b0};
                carry_next = acc[15];
            end
            tiny_acc_pkg::A_RTR: begin
                acc_next   = {1'b0, acc[15:1]};
                carry_next = acc[0];
            end
            tiny_acc_pkg::A_NOT: acc_next = ~acc;
            tiny_acc_pkg::A_COM: acc_next = ~acc + 16'd1;
            tiny_acc_pkg::A_SET: acc_next[bit_idx] = 1'b1;
            tiny_acc_pkg::A_CLR: acc_next[bit_idx] = 1'b0;
            tiny_acc_pkg::A_BSL: begin
                // bit 16 of the shifted word is the last bit pushed out
                wide       = {1'b0, acc} << bit_idx;
                acc_next   = wide[15:0];
                carry_next = wide[16];
            end
            tiny_acc_pkg::A_CLW:     acc_next = '0;
            tiny_acc_pkg::A_IN_LOAD: acc_next = in;
            // a_none holds
            default: acc_next = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc   <= '0;
            flags <= '0;
        end else if (alu_op != tiny_acc_pkg::A_NONE) begin
            acc                          <= acc_next;
            flags[tiny_acc_pkg::FLAG_Z] <= acc_next == 16'd0;
            flags[tiny_acc_pkg::FLAG_C] <= carry_next;
            flags[tiny_acc_pkg::FLAG_S] <= acc_next[15];
        end
    end

    // decoder only ever issues the defined operations
    defined_alu_op: assert property (
        @(posedge clk) disable iff (reset)
        alu_op <= tiny_acc_pkg::A_IN_LOAD
    ) else $error("alu: undefined operation code %0d", alu_op);

endmodule

// File: design/tiny_acc_port.sv
// port unit: 16-bit output port register and the bit-test skip pulse
module tiny_acc_port (
    input  logic                   clk,
    input  logic                   reset,
    input  tiny_acc_pkg::port_op_t port_op,
    input  tiny_acc_pkg::bit_idx_t bit_idx,
    input  tiny_acc_pkg::word_t    acc,
    input  tiny_acc_pkg::word_t    in,
    output tiny_acc_pkg::word_t    port,
    output logic                   skip
);

    tiny_acc_pkg::word_t port_next;
    logic                skip_next;
    logic                is_test;

    assign is_test = port_op == tiny_acc_pkg::P_TEST_ACC || port_op == tiny_acc_pkg::P_TEST_IN;

    always_comb begin
        port_next = port;
        skip_next = 1'b0;
        case (port_op)
            tiny_acc_pkg::P_SET:      port_next[bit_idx] = 1'b1;
            tiny_acc_pkg::P_CLEAR:    port_next[bit_idx] = 1'b0;
            // acc here is the value from before this edge
            tiny_acc_pkg::P_MWO:      port_next = acc;
            tiny_acc_pkg::P_CLR_ALL:  port_next = '0;
            tiny_acc_pkg::P_TEST_ACC: skip_next = acc[bit_idx];
            tiny_acc_pkg::P_TEST_IN:  skip_next = in[bit_idx];
            default:                  port_next = port;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            port <= '0;
            skip <= 1'b0;
        end else begin
            port <= port_next;
            skip <= skip_next;
        end
    end

    // back-to-back skips need back-to-back tests
    property skip_run_needs_tests;
        @(posedge clk) disable iff (reset)
        (skip && $past(skip)) |-> ($past(is_test) && $past(is_test, 2));
    endproperty

    skip_run_check: assert property (skip_run_needs_tests)
        else $error("port: skip held high without a test in each cycle");

endmodule

// File: design/tiny_acc_top.sv
// tiny accumulator core top: decoder feeding the accumulator unit and the port unit
module tiny_acc_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  tiny_acc_pkg::word_t  instr,
    input  tiny_acc_pkg::word_t  operand,
    input  tiny_acc_pkg::word_t  in,
    output tiny_acc_pkg::word_t  acc,
    output tiny_acc_pkg::flags_t flags,
    output tiny_acc_pkg::word_t  port,
    output logic                 skip
);

    tiny_acc_pkg::alu_op_t  alu_op;
    tiny_acc_pkg::port_op_t port_op;
    tiny_acc_pkg::bit_idx_t bit_idx;

    tiny_acc_decode decode0 (
        .instr_valid (instr_valid),
        .instr       (instr),
        .alu_op      (alu_op),
        .port_op     (port_op),
        .bit_idx     (bit_idx)
    );

    tiny_acc_alu alu0 (
        .clk     (clk),
        .reset   (reset),
        .alu_op  (alu_op),
        .bit_idx (bit_idx),
        .operand (operand),
        .in      (in),
        .acc     (acc),
        .flags   (flags)
    );

    // port unit sees the accumulator as registered
    tiny_acc_port port0 (
        .clk     (clk),
        .reset   (reset),
        .port_op (port_op),
        .bit_idx (bit_idx),
        .acc     (acc),
        .in      (in),
        .port    (port),
        .skip    (skip)
    );

endmodule

// File: bench/tiny_acc_tb.sv
// testbench for the tiny accumulator core: directed and random runs against a reference model
module tiny_acc_tb;

    typedef struct packed {
        tiny_acc_pkg::word_t  acc;
        tiny_acc_pkg::flags_t flags;
        tiny_acc_pkg::word_t  port;
        logic                 skip;
    } model_t;

    localparam int RESET_LIMIT = 40;
    localparam int RANDOM_COUNT = 2000;

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 instr_valid;
    tiny_acc_pkg::word_t  instr;
    tiny_acc_pkg::word_t  operand;
    tiny_acc_pkg::word_t  in;
    tiny_acc_pkg::word_t  acc;
    tiny_acc_pkg::flags_t flags;
    tiny_acc_pkg::word_t  port;
    logic                 skip;

    int     errors = 0;
    int     checks = 0;
    integer seed = 89;
    logic   timed_out = 1'b0;
    model_t expected;

    tiny_acc_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .operand     (operand),
        .in          (in),
        .acc         (acc),
        .flags       (flags),
        .port        (port),
        .skip        (skip)
    );

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    // next model state for one sampled instruction
    function automatic model_t next_state(model_t cur, logic v, tiny_acc_pkg::word_t ins,
                                          tiny_acc_pkg::word_t b, tiny_acc_pkg::word_t x);
        model_t              nxt;
        tiny_acc_pkg::word_t a;
        tiny_acc_pkg::word_t na;
        logic                c;
        logic                nc;
        logic                chg;
        logic [3:0]          n;
        nxt      = cur;
        nxt.skip = 1'b0;
        a        = cur.acc;
        na       = a;
        c        = cur.flags[tiny_acc_pkg::FLAG_C];
        nc       = c;
        chg      = 1'b0;
        n        = ins[3:0];
        if (v && ins[11:10] == 2'b00 && ins[15:12] != tiny_acc_pkg::OP_NOARG) begin
            chg = 1'b1;
            case (ins[15:12])
                tiny_acc_pkg::OP_LDW: na = b;
                tiny_acc_pkg::OP_ADD: {nc, na} = {1'b0, a} + {1'b0, b};
                tiny_acc_pkg::OP_ADC: {nc, na} = {1'b0, a} + {1'b0, b} + {16'b0, c};
                tiny_acc_pkg::OP_SUB: begin
                    na = a - b;
                    nc = a < b;
                end
                tiny_acc_pkg::OP_SBB: begin
                    na = a - b - {15'b0, c};
                    nc = {1'b0, a} < ({1'b0, b} + {16'b0, c});
                end
                tiny_acc_pkg::OP_AND: na = a & b;
                tiny_acc_pkg::OP_OR:  na = a | b;
                tiny_acc_pkg::OP_XOR: na = a ^ b;
                default: chg = 1'b0;
            endcase
        end else if (v && ins[11:10] == 2'b00) begin
            case (ins[6:4])
                tiny_acc_pkg::GRP_NONE: begin
                    chg = 1'b1;
                    case (ins[3:0])
                        tiny_acc_pkg::SUB_INC: {nc, na} = {1'b0, a} + 17'd1;
                        tiny_acc_pkg::SUB_DEC: begin
                            na = a - 16'd1;
                            nc = a == 16'd0;
                        end
                        tiny_acc_pkg::SUB_RTL: {nc, na} = {a, 1'b0};
                        tiny_acc_pkg::SUB_RTR: {na, nc} = {1'b0, a};
                        tiny_acc_pkg::SUB_NOT: na = ~a;
                        tiny_acc_pkg::SUB_COM: na = 16'd0 - a;
                        tiny_acc_pkg::SUB_CLW: na = 16'd0;
                        tiny_acc_pkg::SUB_MIW: na = x;
                        tiny_acc_pkg::SUB_MWO: begin
                            chg      = 1'b0;
                            nxt.port = a;
                        end
                        tiny_acc_pkg::SUB_CLO: begin
                            chg      = 1'b0;
                            nxt.port = 16'd0;
                        end
                        default: chg = 1'b0;
                    endcase
                end
                tiny_acc_pkg::GRP_BWS: begin
                    chg   = 1'b1;
                    na[n] = 1'b1;
                end
                tiny_acc_pkg::GRP_BWC: begin
                    chg   = 1'b1;
                    na[n] = 1'b0;
                end
                tiny_acc_pkg::GRP_BSL: begin
                    chg = 1'b1;
                    na  = a << n;
                    nc  = (n == 4'd0) ? 1'b0 : a[5'd16 - {1'b0, n}];
                end
                tiny_acc_pkg::GRP_BWJ: nxt.skip = a[n];
                tiny_acc_pkg::GRP_BIJ: nxt.skip = x[n];
                tiny_acc_pkg::GRP_BOS: nxt.port[n] = 1'b1;
                tiny_acc_pkg::GRP_BOC: nxt.port[n] = 1'b0;
                default: nxt.skip = 1'b0;
            endcase
        end
        if (chg) begin
            nxt.acc   = na;
            nxt.flags = {na[15], nc, na == 16'd0};
        end
        return nxt;
    endfunction

    task automatic compare(input string name, input logic [15:0] want, input logic [15:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    // model steps on the edge, outputs are compared half a period later
    initial begin
        expected = '0;
        forever begin
            @(posedge clk);
            if (reset) begin
                expected = '0;
            end else begin
                expected = next_state(expected, instr_valid, instr, operand, in);
            end
            @(negedge clk);
            compare("acc", expected.acc, acc);
            compare("flags", {13'b0, expected.flags}, {13'b0, flags});
            compare("port", expected.port, port);
            compare("skip", {15'b0, expected.skip}, {15'b0, skip});
        end
    end

    task automatic drive(input logic v, input tiny_acc_pkg::word_t i,
                         input tiny_acc_pkg::word_t o, input tiny_acc_pkg::word_t x);
        @(posedge clk);
        #1;
        instr_valid = v;
        instr       = i;
        operand     = o;
        in          = x;
    endtask

    task automatic major(input tiny_acc_pkg::opcode_t opc, input tiny_acc_pkg::word_t b);
        drive(1'b1, {opc, 12'h000}, b, 16'h0000);
    endtask

    task automatic noarg(input logic [3:0] sub, input tiny_acc_pkg::word_t x);
        drive(1'b1, {12'h000, sub}, 16'h0000, x);
    endtask

    task automatic bit_op(input logic [2:0] grp, input logic [3:0] n,
                          input tiny_acc_pkg::word_t x);
        drive(1'b1, {4'h0, 2'b00, 3'b000, grp, n}, 16'h0000, x);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < RESET_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = reset;
    endtask

    task automatic check_all_zero();
        compare("acc", 16'h0000, acc);
        compare("flags", 16'h0000, {13'b0, flags});
        compare("port", 16'h0000, port);
        compare("skip", 16'h0000, {15'b0, skip});
    endtask

    initial begin
        int          i;
        logic [31:0] r1;
        logic [31:0] r2;
        instr_valid = 1'b0;
        instr       = 16'h0000;
        operand     = 16'h0000;
        in          = 16'h0000;
        wait_reset_release();
        if (timed_out) begin
            $display("Timeout: reset still asserted after %0d cycles", RESET_LIMIT);
            $display("Testbench failed");
        end else begin
            // idle words must not reach the core
            for (i = 0; i < 10; i++) begin
                r1 = $random(seed);
                drive(1'b0, r1[15:0], r1[31:16], r1[23:8]);
            end
            check_all_zero();

            // arithmetic with carry, borrow, zero and negative results
            major(tiny_acc_pkg::OP_LDW, 16'h7fff);
            major(tiny_acc_pkg::OP_ADD, 16'h0001);
            major(tiny_acc_pkg::OP_ADD, 16'h8000);
            major(tiny_acc_pkg::OP_ADC, 16'h0001);
            major(tiny_acc_pkg::OP_SUB, 16'h0003);
            major(tiny_acc_pkg::OP_SBB, 16'hffff);
            major(tiny_acc_pkg::OP_SBB, 16'h0000);
            major(tiny_acc_pkg::OP_SUB, 16'hfffe);
            drive(1'b1, {tiny_acc_pkg::OP_LDW, 2'b01, 10'h000}, 16'hbeef, 16'h0000);
            major(tiny_acc_pkg::OP_LDW, 16'hf0f0);
            major(tiny_acc_pkg::OP_AND, 16'h0ff0);
            major(tiny_acc_pkg::OP_OR,  16'h8001);
            major(tiny_acc_pkg::OP_XOR, 16'h80f1);

            // no-argument and bit operations
            major(tiny_acc_pkg::OP_LDW, 16'hffff);
            noarg(tiny_acc_pkg::SUB_INC, 16'h0000);
            noarg(tiny_acc_pkg::SUB_DEC, 16'h0000);
            noarg(tiny_acc_pkg::SUB_RTL, 16'h0000);
            noarg(tiny_acc_pkg::SUB_RTR, 16'h0000);
            noarg(tiny_acc_pkg::SUB_NOT, 16'h0000);
            noarg(tiny_acc_pkg::SUB_COM, 16'h0000);
            noarg(tiny_acc_pkg::SUB_CLW, 16'h0000);
            noarg(tiny_acc_pkg::SUB_MIW, 16'hc3a5);
            bit_op(tiny_acc_pkg::GRP_BWS, 4'd3, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BWC, 4'd15, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BSL, 4'd0, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BSL, 4'd1, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BSL, 4'd15, 16'h0000);

            // port writes mixed with accumulator changes
            major(tiny_acc_pkg::OP_LDW, 16'h1234);
            noarg(tiny_acc_pkg::SUB_MWO, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BOS, 4'd0, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BOC, 4'd4, 16'h0000);
            noarg(tiny_acc_pkg::SUB_INC, 16'h0000);
            noarg(tiny_acc_pkg::SUB_MWO, 16'h0000);
            noarg(tiny_acc_pkg::SUB_CLO, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BOS, 4'd15, 16'h0000);

            // bit tests, two of them back to back
            major(tiny_acc_pkg::OP_LDW, 16'h0005);
            bit_op(tiny_acc_pkg::GRP_BWJ, 4'd0, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BWJ, 4'd2, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BWJ, 4'd1, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BIJ, 4'd7, 16'h0080);
            bit_op(tiny_acc_pkg::GRP_BIJ, 4'd7, 16'h0000);
            bit_op(tiny_acc_pkg::GRP_BIJ, 4'd15, 16'h8000);
            drive(1'b0, 16'h0000, 16'h0000, 16'h0000);

            for (i = 0; i < RANDOM_COUNT; i++) begin
                r1 = $random(seed);
                r2 = $random(seed);
                // steer about half the words into the no-argument and bit groups
                if (r2[18]) begin
                    r1[15:10] = 6'b000000;
                end
                if (r2[18] && r2[19]) begin
                    r1[6:4] = 3'b000;
                end
                drive(r2[17:16] != 2'b00, r1[15:0], r1[31:16], r2[15:0]);
            end
            drive(1'b0, 16'h0000, 16'h0000, 16'h0000);
            repeat (2) @(negedge clk);

            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
        end
        $finish;
    end

endmodule

// File: tiny_acc.f
design/tiny_acc_pkg.sv
design/tiny_acc_decode.sv
design/tiny_acc_alu.sv
design/tiny_acc_port.sv
design/tiny_acc_top.sv
bench/tiny_acc_tb.sv

// File: Bender.yml
package:
  name: tiny_acc

sources:
  - design/tiny_acc_pkg.sv
  - design/tiny_acc_decode.sv
  - design/tiny_acc_alu.sv
  - design/tiny_acc_port.sv
  - design/tiny_acc_top.sv
  - target: test
    files:
      - bench/tiny_acc_tb.sv
